// ==== rtl/mul_div_config.svh ====
`ifndef MUL_DIV_CONFIG_SVH
`define MUL_DIV_CONFIG_SVH

// operand and result width, 32 or 64
`define MD_XLEN 32

// booth digits of the xlen+2 bit multiplier, two per step
`define MD_MUL_STEPS ((`MD_XLEN + 4) / 4)

// two quotient bits per step
`define MD_DIV_STEPS (`MD_XLEN / 2)

// holds the larger step count minus one
`define MD_COUNT_W 5

`endif

// ==== rtl/mul_div_pkg.sv ====
package mul_div_pkg;

   typedef enum logic {
      MD_OP_MUL = 1'b0,
      MD_OP_DIV = 1'b1
   } md_op_e;

   // lo is product low word or quotient, hi is product high word or remainder
   typedef enum logic {
      MD_OUT_LO = 1'b0,
      MD_OUT_HI = 1'b1
   } md_out_sel_e;

   typedef enum logic [1:0] {
      MD_IDLE = 2'd0,
      MD_MUL  = 2'd1,
      MD_DIV  = 2'd2,
      MD_DONE = 2'd3
   } md_state_e;

endpackage

// ==== rtl/mul_div_decode.sv ====
`timescale 1ns/1ps
`include "mul_div_config.svh"

module mul_div_decode (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     req_valid,
   input  mul_div_pkg::md_op_e      req_op,
   input  logic                     req_in_1_signed,
   input  logic                     req_in_2_signed,
   input  mul_div_pkg::md_out_sel_e req_out_sel,
   input  logic [`MD_XLEN-1:0]      req_in_1,
   input  logic [`MD_XLEN-1:0]      req_in_2,
   output logic                     req_ready,
   output logic                     mul_start,
   output logic                     div_start,
   output logic                     step_en,
   output logic                     finish,
   output logic [`MD_XLEN:0]        mul_multiplicand,
   output logic [`MD_XLEN+1:0]      mul_multiplier,
   output logic [`MD_XLEN-1:0]      div_dividend,
   output logic [`MD_XLEN-1:0]      div_divisor,
   output mul_div_pkg::md_op_e      result_op,
   output mul_div_pkg::md_out_sel_e result_sel,
   output logic                     neg_quotient,
   output logic                     neg_remainder,
   output logic                     div_by_zero,
   output logic [`MD_XLEN-1:0]      dividend_raw
);

   localparam int XLEN = `MD_XLEN;
   localparam int CW   = `MD_COUNT_W;

   mul_div_pkg::md_state_e state;
   logic [CW-1:0]          count;
   logic                   accept;
   logic                   divisor_zero;
   logic                   in_1_neg;
   logic                   in_2_neg;

   assign accept       = req_valid & req_ready;
   assign req_ready    = (state == mul_div_pkg::MD_IDLE) | (state == mul_div_pkg::MD_DONE);
   assign step_en      = (state == mul_div_pkg::MD_MUL) | (state == mul_div_pkg::MD_DIV);
   assign finish       = (state == mul_div_pkg::MD_DONE);
   assign divisor_zero = (req_in_2 == '0);

   assign mul_start = accept & (req_op == mul_div_pkg::MD_OP_MUL);
   assign div_start = accept & (req_op == mul_div_pkg::MD_OP_DIV) & ~divisor_zero;

   assign mul_multiplicand = {req_in_1_signed & req_in_1[XLEN-1], req_in_1};
   assign mul_multiplier   = {{2{req_in_2_signed & req_in_2[XLEN-1]}}, req_in_2};

   // divide signedness comes from the in_1 flag only
   assign in_1_neg     = req_in_1_signed & req_in_1[XLEN-1];
   assign in_2_neg     = req_in_1_signed & req_in_2[XLEN-1];
   assign div_dividend = in_1_neg ? -req_in_1 : req_in_1;
   assign div_divisor  = in_2_neg ? -req_in_2 : req_in_2;

   always_ff @(posedge clk) begin
      if (accept) begin
         result_op     <= req_op;
         result_sel    <= req_out_sel;
         neg_quotient  <= in_1_neg ^ in_2_neg;
         neg_remainder <= in_1_neg; // remainder follows dividend
         div_by_zero   <= (req_op == mul_div_pkg::MD_OP_DIV) & divisor_zero;
         dividend_raw  <= req_in_1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= mul_div_pkg::MD_IDLE;
         count <= '0;
      end else if (accept) begin
         if (req_op == mul_div_pkg::MD_OP_MUL) begin
            state <= mul_div_pkg::MD_MUL;
            count <= CW'(`MD_MUL_STEPS - 1);
         end else if (divisor_zero) begin
            state <= mul_div_pkg::MD_DONE; // nothing to iterate
         end else begin
            state <= mul_div_pkg::MD_DIV;
            count <= CW'(`MD_DIV_STEPS - 1);
         end
      end else if (step_en) begin
         if (count == '0) begin
            state <= mul_div_pkg::MD_DONE;
         end
         count <= count - 1'b1;
      end else if (finish) begin
         state <= mul_div_pkg::MD_IDLE;
      end
   end

   // steps only follow a start or another step, never an idle cycle
   a_step_after_start: assert property (@(posedge clk) disable iff (reset)
      step_en |-> $past(mul_start | div_start | step_en));

   a_op_known: assert property (@(posedge clk) disable iff (reset)
      accept |-> !$isunknown(req_op));

   // a divide carries one signedness for both operands
   a_div_signed: assert property (@(posedge clk) disable iff (reset)
      accept && req_op == mul_div_pkg::MD_OP_DIV |-> req_in_1_signed == req_in_2_signed);

endmodule

// ==== rtl/mul_booth_step.sv ====
`timescale 1ns/1ps
`include "mul_div_config.svh"

module mul_booth_step (
   input  logic                   clk,
   input  logic                   mul_start,
   input  logic                   step_en,
   input  logic [`MD_XLEN:0]      mul_multiplicand,
   input  logic [`MD_XLEN+1:0]    mul_multiplier,
   output logic [2*`MD_XLEN-1:0]  mul_product
);

   localparam int XLEN = `MD_XLEN;

   logic [2*XLEN-1:0] mc;  // multiplicand, moves up four bits a step
   logic [XLEN+2:0]   mr;  // multiplier with the implicit zero below bit 0
   logic [2*XLEN-1:0] acc;
   logic [2*XLEN-1:0] pp0;
   logic [2*XLEN-1:0] pp1;

   function automatic logic [2*XLEN-1:0] booth_pp(input logic [2:0]        digit,
                                                  input logic [2*XLEN-1:0] m);
      logic [2*XLEN-1:0] pp;
      case (digit)
         3'b001, 3'b010: pp = m;
         3'b011:         pp = m << 1;
         3'b100:         pp = -(m << 1);
         3'b101, 3'b110: pp = -m;
         default:        pp = '0;
      endcase
      return pp;
   endfunction

   assign pp0 = booth_pp(mr[2:0], mc);
   assign pp1 = booth_pp(mr[4:2], mc) << 2; // only sign bits left on the last step

   always_ff @(posedge clk) begin
      if (mul_start) begin
         mc  <= {{(XLEN-1){mul_multiplicand[XLEN]}}, mul_multiplicand};
         mr  <= {mul_multiplier, 1'b0};
         acc <= '0;
      end else if (step_en) begin
         acc <= acc + pp0 + pp1;
         mc  <= mc << 4;
         mr  <= {{4{mr[XLEN+2]}}, mr[XLEN+2:4]}; // arithmetic shift
      end
   end

   assign mul_product = acc;

   // decode must leave the load cycle free of steps
   a_start_no_step: assert property (@(posedge clk) !(mul_start && step_en));

endmodule

// ==== rtl/div_radix4_step.sv ====
`timescale 1ns/1ps
`include "mul_div_config.svh"

module div_radix4_step (
   input  logic                 clk,
   input  logic                 div_start,
   input  logic                 step_en,
   input  logic [`MD_XLEN-1:0]  div_dividend,
   input  logic [`MD_XLEN-1:0]  div_divisor,
   output logic [`MD_XLEN-1:0]  div_quotient,
   output logic [`MD_XLEN-1:0]  div_remainder
);

   localparam int XLEN = `MD_XLEN;

   logic [XLEN-1:0] rem;
   logic [XLEN-1:0] quo;   // dividend bits leave the top, quotient bits enter below
   logic [XLEN-1:0] d;
   logic [XLEN+1:0] trial;
   logic [XLEN+1:0] d1;
   logic [XLEN+1:0] d2;
   logic [XLEN+1:0] d3;
   logic [XLEN+2:0] sub1;
   logic [XLEN+2:0] sub2;
   logic [XLEN+2:0] sub3;
   logic [1:0]      q_bits;
   logic [XLEN-1:0] rem_next;

   assign trial = {rem, quo[XLEN-1:XLEN-2]};
   assign d1    = {2'b00, d};
   assign d2    = {1'b0, d, 1'b0};
   assign d3    = d1 + d2;

   // three trial subtractions in parallel, msb set means negative
   assign sub1 = {1'b0, trial} - {1'b0, d1};
   assign sub2 = {1'b0, trial} - {1'b0, d2};
   assign sub3 = {1'b0, trial} - {1'b0, d3};

   always_comb begin
      if (!sub3[XLEN+2]) begin
         q_bits   = 2'd3;
         rem_next = sub3[XLEN-1:0];
      end else if (!sub2[XLEN+2]) begin
         q_bits   = 2'd2;
         rem_next = sub2[XLEN-1:0];
      end else if (!sub1[XLEN+2]) begin
         q_bits   = 2'd1;
         rem_next = sub1[XLEN-1:0];
      end else begin
         q_bits   = 2'd0;
         rem_next = trial[XLEN-1:0]; // restore
      end
   end

   always_ff @(posedge clk) begin
      if (div_start) begin
         rem <= '0;
         quo <= div_dividend;
         d   <= div_divisor;
      end else if (step_en) begin
         rem <= rem_next;
         quo <= {quo[XLEN-3:0], q_bits};
      end
   end

   assign div_quotient  = quo;
   assign div_remainder = rem;

   // zero divisors are answered by decode without a start
   a_no_zero_divisor: assert property (@(posedge clk) div_start |-> div_divisor != '0);

endmodule

// ==== rtl/mul_div_result.sv ====
`timescale 1ns/1ps
`include "mul_div_config.svh"

module mul_div_result (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     finish,
   input  mul_div_pkg::md_op_e      result_op,
   input  mul_div_pkg::md_out_sel_e result_sel,
   input  logic                     neg_quotient,
   input  logic                     neg_remainder,
   input  logic                     div_by_zero,
   input  logic [`MD_XLEN-1:0]      dividend_raw,
   input  logic [2*`MD_XLEN-1:0]    mul_product,
   input  logic [`MD_XLEN-1:0]      div_quotient,
   input  logic [`MD_XLEN-1:0]      div_remainder,
   output logic                     resp_valid,
   output logic [`MD_XLEN-1:0]      resp_result
);

   localparam int XLEN = `MD_XLEN;

   logic [XLEN-1:0] quotient;
   logic [XLEN-1:0] remainder;
   logic [XLEN-1:0] value;

   always_comb begin
      quotient  = neg_quotient ? -div_quotient : div_quotient;
      remainder = neg_remainder ? -div_remainder : div_remainder;
      if (div_by_zero) begin
         quotient  = '1;            // riscv divide by zero
         remainder = dividend_raw;
      end
      if (result_op == mul_div_pkg::MD_OP_MUL) begin
         if (result_sel == mul_div_pkg::MD_OUT_HI) begin
            value = mul_product[2*XLEN-1:XLEN];
         end else begin
            value = mul_product[XLEN-1:0];
         end
      end else begin
         value = (result_sel == mul_div_pkg::MD_OUT_HI) ? remainder : quotient;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= finish;
      end
   end

   always_ff @(posedge clk) begin
      if (finish) begin
         resp_result <= value; // held until next response
      end
   end

endmodule

// ==== rtl/mul_div.sv ====
`timescale 1ns/1ps
`include "mul_div_config.svh"

module mul_div (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     req_valid,
   input  mul_div_pkg::md_op_e      req_op,
   input  logic                     req_in_1_signed,
   input  logic                     req_in_2_signed,
   input  mul_div_pkg::md_out_sel_e req_out_sel,
   input  logic [`MD_XLEN-1:0]      req_in_1,
   input  logic [`MD_XLEN-1:0]      req_in_2,
   output logic                     req_ready,
   output logic                     resp_valid,
   output logic [`MD_XLEN-1:0]      resp_result
);

   logic                     mul_start;
   logic                     div_start;
   logic                     step_en;
   logic                     finish;
   logic [`MD_XLEN:0]        mul_multiplicand;
   logic [`MD_XLEN+1:0]      mul_multiplier;
   logic [`MD_XLEN-1:0]      div_dividend;
   logic [`MD_XLEN-1:0]      div_divisor;
   mul_div_pkg::md_op_e      result_op;
   mul_div_pkg::md_out_sel_e result_sel;
   logic                     neg_quotient;
   logic                     neg_remainder;
   logic                     div_by_zero;
   logic [`MD_XLEN-1:0]      dividend_raw;
   logic [2*`MD_XLEN-1:0]    mul_product;
   logic [`MD_XLEN-1:0]      div_quotient;
   logic [`MD_XLEN-1:0]      div_remainder;

   mul_div_decode decode0 (
      .clk, .reset, .req_valid, .req_op, .req_in_1_signed, .req_in_2_signed,
      .req_out_sel, .req_in_1, .req_in_2, .req_ready, .mul_start, .div_start,
      .step_en, .finish, .mul_multiplicand, .mul_multiplier, .div_dividend,
      .div_divisor, .result_op, .result_sel, .neg_quotient, .neg_remainder,
      .div_by_zero, .dividend_raw
   );

   mul_booth_step mul0 (
      .clk, .mul_start, .step_en, .mul_multiplicand, .mul_multiplier, .mul_product
   );

   div_radix4_step div0 (
      .clk, .div_start, .step_en, .div_dividend, .div_divisor, .div_quotient,
      .div_remainder
   );

   mul_div_result result0 (
      .clk, .reset, .finish, .result_op, .result_sel, .neg_quotient, .neg_remainder,
      .div_by_zero, .dividend_raw, .mul_product, .div_quotient, .div_remainder,
      .resp_valid, .resp_result
   );

endmodule

// ==== dv/mul_div_tb.sv ====
`timescale 1ns/1ps
`include "mul_div_config.svh"

module mul_div_tb;

   localparam int XLEN       = `MD_XLEN;
   localparam int VECTORS    = 64;
   localparam int WAIT_LIMIT = 100;

   logic                     clk;
   logic                     reset;
   logic                     req_valid;
   mul_div_pkg::md_op_e      req_op;
   logic                     req_in_1_signed;
   logic                     req_in_2_signed;
   mul_div_pkg::md_out_sel_e req_out_sel;
   logic [XLEN-1:0]          req_in_1;
   logic [XLEN-1:0]          req_in_2;
   logic                     req_ready;
   logic                     resp_valid;
   logic [XLEN-1:0]          resp_result;

   logic [XLEN-1:0] stim_mem [0:7*VECTORS-1]; // seven columns per vector
   logic [XLEN-1:0] exp_result_q [$];
   int              exp_cycle_q [$];
   int              cycle = 0;

   mul_div dut0 (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                              input logic [XLEN-1:0] expected);
      if (actual !== expected) begin
         abort_run($sformatf("Error: %s = %h, expected %h", name, actual, expected));
      end
   endtask

   // riscv rules in wide signed arithmetic, divide signedness from in_1 flag
   function automatic logic [XLEN-1:0] model_result(input logic op, input logic s1,
         input logic s2, input logic sel, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      logic signed [2*XLEN+1:0] wa;
      logic signed [2*XLEN+1:0] wb;
      logic signed [2*XLEN+1:0] wide;
      logic                     b_signed;
      logic [XLEN-1:0]          res;
      b_signed = op ? s1 : s2;
      wa = s1 ? {{(XLEN+2){a[XLEN-1]}}, a} : {{(XLEN+2){1'b0}}, a};
      wb = b_signed ? {{(XLEN+2){b[XLEN-1]}}, b} : {{(XLEN+2){1'b0}}, b};
      if (!op) begin
         wide = wa * wb;
         res  = sel ? wide[2*XLEN-1:XLEN] : wide[XLEN-1:0];
      end else if (b == '0) begin
         res = sel ? a : '1;
      end else begin
         wide = sel ? wa % wb : wa / wb;
         res  = wide[XLEN-1:0];
      end
      return res;
   endfunction

   // edges from accept to the edge that raises resp_valid
   function automatic int latency(input logic op, input logic [XLEN-1:0] b);
      int edges;
      if (!op) begin
         edges = `MD_MUL_STEPS + 1;
      end else if (b == '0) begin
         edges = 1;
      end else begin
         edges = `MD_DIV_STEPS + 1;
      end
      return edges;
   endfunction

   function automatic logic [XLEN-1:0] pick_operand();
      logic [XLEN-1:0] val;
      case ($urandom() % 8)
         0: val = '0;
         1: val = '1;
         2: val = {1'b1, {(XLEN-1){1'b0}}};
         3: val = XLEN'($urandom() % 16);
         default: val = XLEN'({$urandom(), $urandom()});
      endcase
      return val;
   endfunction

   task automatic drive_inputs(input logic valid, input logic op, input logic s1, input logic s2,
         input logic sel, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      req_valid       = valid;
      req_op          = mul_div_pkg::md_op_e'(op);
      req_in_1_signed = s1;
      req_in_2_signed = s2;
      req_out_sel     = mul_div_pkg::md_out_sel_e'(sel);
      req_in_1        = a;
      req_in_2        = b;
   endtask

   task automatic issue_request(input logic op, input logic s1, input logic s2, input logic sel,
         input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] expected);
      int waited;
      waited = 0;
      drive_inputs(1'b1, op, s1, s2, sel, a, b);
      while (!req_ready) begin
         if (waited == WAIT_LIMIT) begin
            abort_run("timed out waiting for req_ready to rise");
         end
         @(posedge clk);
         #2;
         waited++;
      end
      @(posedge clk); // accepting edge
      #2;
      exp_result_q.push_back(expected);
      exp_cycle_q.push_back(cycle + latency(op, b));
      req_valid = 1'b0;
   endtask

   task automatic drain_responses();
      int waited;
      waited = 0;
      while (exp_result_q.size() != 0) begin
         if (waited == WAIT_LIMIT) begin
            abort_run("timed out waiting for resp_valid");
         end
         @(posedge clk);
         #2;
         waited++;
      end
      repeat (4) @(posedge clk); // room for a stray pulse
      #2;
   endtask

   task automatic run_stim_file();
      int              base;
      int              loaded;
      logic [XLEN-1:0] model;
      loaded = 0;
      for (int v = 0; v < VECTORS; v++) begin
         base = 7 * v;
         if (stim_mem[base] > 1) begin
            break; // fill pattern, past the last vector
         end
         model = model_result(stim_mem[base][0], stim_mem[base+1][0], stim_mem[base+2][0],
                              stim_mem[base+3][0], stim_mem[base+4], stim_mem[base+5]);
         check_value("stim expected vs model", model, stim_mem[base+6]);
         issue_request(stim_mem[base][0], stim_mem[base+1][0], stim_mem[base+2][0],
                       stim_mem[base+3][0], stim_mem[base+4], stim_mem[base+5],
                       stim_mem[base+6]);
         drain_responses();
         loaded++;
      end
      if (loaded == 0) begin
         abort_run("no vectors were read from dv/mul_div_stim.txt");
      end
   endtask

   // a second request while busy must be dropped
   task automatic busy_ignore(input logic op, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b);
      issue_request(op, 1'b1, 1'b1, 1'b0, a, b, model_result(op, 1'b1, 1'b1, 1'b0, a, b));
      drive_inputs(1'b1, op, 1'b0, 1'b0, 1'b1, ~a, b + 1'b1);
      repeat (4) begin
         check_value("req_ready", XLEN'(req_ready), '0);
         @(posedge clk);
         #2;
      end
      req_valid = 1'b0;
      drain_responses();
   endtask

   task automatic run_random();
      logic            op;
      logic            s1;
      logic            s2;
      logic            sel;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      for (int i = 0; i < 200; i++) begin
         op  = 1'($urandom());
         s1  = 1'($urandom());
         s2  = op ? s1 : 1'($urandom());
         sel = 1'($urandom());
         a   = pick_operand();
         b   = pick_operand();
         issue_request(op, s1, s2, sel, a, b, model_result(op, s1, s2, sel, a, b));
      end
      drain_responses();
   endtask

   initial begin
      forever begin
         @(negedge clk);
         if (resp_valid === 1'b1) begin
            if (exp_result_q.size() == 0) begin
               abort_run("resp_valid pulsed with no request pending");
            end else begin
               check_value("resp_result", resp_result, exp_result_q.pop_front());
               check_value("response cycle", XLEN'(cycle), XLEN'(exp_cycle_q.pop_front()));
            end
         end
      end
   end

   initial begin
      void'($urandom(32'h012eb521));
      reset = 1'b1;
      drive_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
      for (int i = 0; i < 7 * VECTORS; i++) begin
         stim_mem[i] = {4'hf, (XLEN-4)'(i)};
      end
      $readmemh("dv/mul_div_stim.txt", stim_mem);
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;
      check_value("req_ready", XLEN'(req_ready), XLEN'(1));
      check_value("resp_valid", XLEN'(resp_valid), '0);
      run_stim_file();
      busy_ignore(1'b0, 32'h1234_5678, 32'h9abc_def0);
      busy_ignore(1'b1, 32'h8765_4321, 32'h0000_0123);
      run_random();
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== mul_div.f ====
+incdir+rtl
rtl/mul_div_pkg.sv
rtl/mul_div_decode.sv
rtl/mul_booth_step.sv
rtl/div_radix4_step.sv
rtl/mul_div_result.sv
rtl/mul_div.sv
dv/mul_div_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vmul_div_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): mul_div.f rtl/mul_div_config.svh rtl/mul_div_pkg.sv rtl/mul_div_decode.sv \
		rtl/mul_booth_step.sv rtl/div_radix4_step.sv rtl/mul_div_result.sv \
		rtl/mul_div.sv dv/mul_div_tb.sv
	verilator --binary --timing --assert --top-module mul_div_tb -f mul_div.f \
		--Mdir obj_dir -o Vmul_div_tb

clean:
	rm -rf obj_dir

// ==== dv/mul_div_stim.txt ====
// columns: op (0 mul, 1 div), in_1_signed, in_2_signed, out_sel (0 lo, 1 hi),
// in_1, in_2, expected resp_result, all hex
0 0 0 0 00000007 00000006 0000002a
0 1 1 0 fffffff9 00000006 ffffffd6
0 1 1 1 fffffff9 00000006 ffffffff
0 1 1 0 80000000 80000000 00000000
0 1 1 1 80000000 80000000 40000000
0 1 1 0 ffffffff ffffffff 00000001
0 1 1 1 ffffffff ffffffff 00000000
0 0 0 0 ffffffff ffffffff 00000001
0 0 0 1 ffffffff ffffffff fffffffe
0 1 0 1 ffffffff ffffffff ffffffff
0 1 0 0 ffffffff ffffffff 00000001
0 0 1 1 ffffffff ffffffff ffffffff
0 0 0 1 00010000 00010000 00000001
0 1 0 1 80000000 80000000 c0000000
0 0 0 1 80000000 80000000 40000000
0 0 1 0 80000000 ffffffff 80000000
0 0 0 0 0000ffff 0000ffff fffe0001
0 1 1 1 7fffffff 7fffffff 3fffffff
0 1 1 0 7fffffff 7fffffff 00000001
0 1 1 1 7fffffff 80000000 c0000000
1 0 0 0 00000064 00000007 0000000e
1 0 0 1 00000064 00000007 00000002
1 1 1 0 ffffff9c 00000007 fffffff2
1 1 1 1 ffffff9c 00000007 fffffffe
1 1 1 0 00000064 fffffff9 fffffff2
1 1 1 1 00000064 fffffff9 00000002
1 1 1 0 ffffff9c fffffff9 0000000e
1 1 1 1 ffffff9c fffffff9 fffffffe
1 0 0 0 ffffff9c 00000007 24924916
1 0 0 1 ffffff9c 00000007 00000002
1 0 0 0 ffffffff 00000001 ffffffff
1 0 0 0 00000005 ffffffff 00000000
1 0 0 1 00000005 ffffffff 00000005
1 1 1 0 00000007 ffffff9c 00000000
1 1 1 1 00000007 ffffff9c 00000007
1 0 0 0 12345678 00000000 ffffffff
1 0 0 1 12345678 00000000 12345678
1 1 1 0 87654321 00000000 ffffffff
1 1 1 1 87654321 00000000 87654321
1 1 1 0 80000000 ffffffff 80000000
1 1 1 1 80000000 ffffffff 00000000
1 1 1 0 80000000 00000001 80000000
